// ==== rv_frontend_defs.svh ====
`ifndef RV_FRONTEND_DEFS_SVH
`define RV_FRONTEND_DEFS_SVH

// Address and instruction width
`define RV_XLEN 32

// Reset value of the boot address register
`define RV_BOOT_ADDR 32'h0000_0100

// Configuration register addresses
`define RV_CFG_BOOT 1'b0
`define RV_CFG_CTRL 1'b1

// Fetched instruction counter width
`define RV_TICK_W 16

`endif

// ==== rv_frontend_pkg.sv ====
`default_nettype none

`include "rv_frontend_defs.svh"

package rv_frontend_pkg;

    typedef logic [`RV_XLEN-1:0]   inst_addr_t;   // Program counter
    typedef logic [`RV_XLEN-1:0]   inst_t;        // Instruction word
    typedef logic [`RV_TICK_W-1:0] tick_t;        // Fetch count

    // Instruction class seen by the decoder
    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_alu_imm,
        op_alu_reg,
        op_system,
        op_compressed,     // Low bits not 11, not expanded
        op_illegal
    } opcode_e;

endpackage

`default_nettype wire

// ==== fetch_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fetch_bus_if;

    logic                        valid;        // Slot holds a real instruction
    rv_frontend_pkg::inst_addr_t pc;           // Address of the instruction
    rv_frontend_pkg::inst_t      inst;         // Raw instruction word
    logic                        compressed;   // 16-bit encoding
    rv_frontend_pkg::tick_t      tick;         // Fetch count of this slot

    modport producer (
        output valid,
        output pc,
        output inst,
        output compressed,
        output tick
    );

    modport consumer (
        input valid,
        input pc,
        input inst,
        input compressed,
        input tick
    );

endinterface

`default_nettype wire

// ==== rv_frontend_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defs.svh"

module rv_frontend_regs (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_cfg_write,   // Write strobe
    input  logic                        i_cfg_addr,    // Register select
    input  logic [`RV_XLEN-1:0]         i_cfg_data,
    output rv_frontend_pkg::inst_addr_t o_boot_addr,   // Restart target
    output logic                        o_halt,        // Freezes the front end
    output logic                        o_restart      // One-cycle pulse
);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_boot_addr <= `RV_BOOT_ADDR;
            o_halt      <= 1'b0;
            o_restart   <= 1'b0;
        end
        else
        begin
            o_restart <= 1'b0;                     // Default low, pulse only on write
            if (i_cfg_write)
            begin
                case (i_cfg_addr)
                    `RV_CFG_BOOT:
                        o_boot_addr <= i_cfg_data;
                    `RV_CFG_CTRL:
                    begin
                        o_halt    <= i_cfg_data[0];
                        o_restart <= i_cfg_data[1];
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv_fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defs.svh"

module rv_fetch_stage (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_stall,           // Freeze PC and tick
    input  rv_frontend_pkg::inst_addr_t i_boot_addr,
    input  logic                        i_restart,
    input  logic                        i_redirect,        // JAL seen in decode
    input  rv_frontend_pkg::inst_addr_t i_redirect_target,
    input  rv_frontend_pkg::inst_t      i_imem_data,       // Same-cycle memory data
    output rv_frontend_pkg::inst_addr_t o_imem_addr,
    fetch_bus_if.producer               o_bus
);

    rv_frontend_pkg::inst_addr_t pc;
    rv_frontend_pkg::tick_t      tick;
    logic                        compressed;
    logic                        squash;

    assign compressed = i_imem_data[1:0] != 2'b11;
    assign squash     = i_restart | i_redirect;   // Current word is on the wrong path

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            pc   <= `RV_BOOT_ADDR;
            tick <= '0;
        end
        else if (i_restart)
            pc <= i_boot_addr;
        else if (i_redirect)
            pc <= i_redirect_target;
        else if (!i_stall)
        begin
            pc   <= pc + rv_frontend_pkg::inst_addr_t'(compressed ? 2 : 4);
            tick <= tick + rv_frontend_pkg::tick_t'(1);
        end
    end

    assign o_imem_addr = pc;

    assign o_bus.valid      = !squash;
    assign o_bus.pc         = pc;
    assign o_bus.inst       = i_imem_data;
    assign o_bus.compressed = compressed;
    assign o_bus.tick       = tick;

endmodule

`default_nettype wire

// ==== rv_pipeline_if_id.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defs.svh"

module rv_pipeline_if_id (
    input  logic          i_clock,
    input  logic          i_reset,
    input  logic          i_stall,   // Hold the current slot
    input  logic          i_flush,   // Load a bubble
    fetch_bus_if.consumer i_bus,
    fetch_bus_if.producer o_bus
);

    always_ff @(posedge i_clock)
    begin
        casez ({i_reset, i_flush, i_stall})
            3'b1??:   // Reset
            begin
                o_bus.valid      <= 1'b0;
                o_bus.pc         <= `RV_BOOT_ADDR - 32'd4;   // One slot before boot
                o_bus.inst       <= '0;
                o_bus.compressed <= 1'b0;
                o_bus.tick       <= '0;
            end

            3'b01?:   // Flush
            begin
                o_bus.valid      <= 1'b0;
                o_bus.pc         <= i_bus.pc;
                o_bus.inst       <= '0;
                o_bus.compressed <= 1'b0;
                o_bus.tick       <= i_bus.tick;
            end

            3'b001:   // Stall
            begin
                o_bus.valid      <= o_bus.valid;
                o_bus.pc         <= o_bus.pc;
                o_bus.inst       <= o_bus.inst;
                o_bus.compressed <= o_bus.compressed;
                o_bus.tick       <= o_bus.tick;
            end

            default:  // Normal
            begin
                o_bus.valid      <= i_bus.valid;
                o_bus.pc         <= i_bus.pc;
                o_bus.inst       <= i_bus.inst;
                o_bus.compressed <= i_bus.compressed;
                o_bus.tick       <= i_bus.tick;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defs.svh"

module rv_decode_stage (
    input  logic                        i_stall,
    fetch_bus_if.consumer               i_bus,
    output logic                        o_valid,
    output rv_frontend_pkg::inst_addr_t o_pc,
    output rv_frontend_pkg::opcode_e    o_opcode,
    output logic [4:0]                  o_rd,
    output logic [4:0]                  o_rs1,
    output logic [4:0]                  o_rs2,
    output logic [`RV_XLEN-1:0]         o_imm,
    output logic                        o_redirect,        // Also flushes IF/ID
    output rv_frontend_pkg::inst_addr_t o_redirect_target
);

    rv_frontend_pkg::inst_t   inst;
    logic [`RV_XLEN-1:0]      imm_j;

    assign inst = i_bus.inst;

    // Major opcode in bits 6:2
    always_comb
    begin
        if (inst == '0)
            o_opcode = rv_frontend_pkg::op_illegal;
        else if (i_bus.compressed)
            o_opcode = rv_frontend_pkg::op_compressed;
        else
        begin
            case (inst[6:2])
                5'b01101: o_opcode = rv_frontend_pkg::op_lui;
                5'b00101: o_opcode = rv_frontend_pkg::op_auipc;
                5'b11011: o_opcode = rv_frontend_pkg::op_jal;
                5'b11001: o_opcode = rv_frontend_pkg::op_jalr;
                5'b11000: o_opcode = rv_frontend_pkg::op_branch;
                5'b00000: o_opcode = rv_frontend_pkg::op_load;
                5'b01000: o_opcode = rv_frontend_pkg::op_store;
                5'b00100: o_opcode = rv_frontend_pkg::op_alu_imm;
                5'b01100: o_opcode = rv_frontend_pkg::op_alu_reg;
                5'b11100: o_opcode = rv_frontend_pkg::op_system;
                default:  o_opcode = rv_frontend_pkg::op_illegal;
            endcase
        end
    end

    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        case (o_opcode)
            rv_frontend_pkg::op_jalr,
            rv_frontend_pkg::op_load,
            rv_frontend_pkg::op_alu_imm,
            rv_frontend_pkg::op_system:           // I-type
                o_imm = {{20{inst[31]}}, inst[31:20]};
            rv_frontend_pkg::op_store:            // S-type
                o_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_frontend_pkg::op_branch:           // B-type
                o_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_frontend_pkg::op_lui,
            rv_frontend_pkg::op_auipc:            // U-type
                o_imm = {inst[31:12], 12'b0};
            rv_frontend_pkg::op_jal:
                o_imm = imm_j;
            default:
                o_imm = '0;                       // No immediate
        endcase
    end

    assign o_valid = i_bus.valid;
    assign o_pc    = i_bus.pc;
    assign o_rd    = inst[11:7];
    assign o_rs1   = inst[19:15];
    assign o_rs2   = inst[24:20];

    // Jump target resolved here, fetch follows on the next edge
    assign o_redirect_target = i_bus.pc + imm_j;
    assign o_redirect        = i_bus.valid && !i_stall &&
                               (o_opcode == rv_frontend_pkg::op_jal);

endmodule

`default_nettype wire

// ==== rv_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defs.svh"

module rv_frontend (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  logic                        i_cfg_write,
    input  logic                        i_cfg_addr,
    input  logic [`RV_XLEN-1:0]         i_cfg_data,
    output rv_frontend_pkg::inst_addr_t o_imem_addr,
    input  rv_frontend_pkg::inst_t      i_imem_data,   // Combinational memory read
    output logic                        o_dec_valid,
    output rv_frontend_pkg::inst_addr_t o_dec_pc,
    output rv_frontend_pkg::opcode_e    o_dec_opcode,
    output logic [4:0]                  o_dec_rd,
    output logic [4:0]                  o_dec_rs1,
    output logic [4:0]                  o_dec_rs2,
    output logic [`RV_XLEN-1:0]         o_dec_imm,
    output rv_frontend_pkg::tick_t      o_dec_tick,
    output logic                        o_redirect
);

    rv_frontend_pkg::inst_addr_t boot_addr;
    rv_frontend_pkg::inst_addr_t redirect_target;
    logic                        halt;
    logic                        restart;
    logic                        stall;
    logic                        flush;

    fetch_bus_if if_bus ();
    fetch_bus_if id_bus ();

    assign stall = i_stall | halt;        // Halt acts as a held stall
    assign flush = o_redirect | restart;

    rv_frontend_regs u_regs (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_cfg_write (i_cfg_write),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_data  (i_cfg_data),
        .o_boot_addr (boot_addr),
        .o_halt      (halt),
        .o_restart   (restart)
    );

    rv_fetch_stage u_fetch (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_stall           (stall),
        .i_boot_addr       (boot_addr),
        .i_restart         (restart),
        .i_redirect        (o_redirect),
        .i_redirect_target (redirect_target),
        .i_imem_data       (i_imem_data),
        .o_imem_addr       (o_imem_addr),
        .o_bus             (if_bus)
    );

    rv_pipeline_if_id u_if_id (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_stall (stall),
        .i_flush (flush),
        .i_bus   (if_bus),
        .o_bus   (id_bus)
    );

    rv_decode_stage u_decode (
        .i_stall           (stall),
        .i_bus             (id_bus),
        .o_valid           (o_dec_valid),
        .o_pc              (o_dec_pc),
        .o_opcode          (o_dec_opcode),
        .o_rd              (o_dec_rd),
        .o_rs1             (o_dec_rs1),
        .o_rs2             (o_dec_rs2),
        .o_imm             (o_dec_imm),
        .o_redirect        (o_redirect),
        .o_redirect_target (redirect_target)
    );

    assign o_dec_tick = id_bus.tick;

endmodule

`default_nettype wire

// ==== rv_frontend_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_frontend_properties (
    input logic                        i_clock,
    input logic                        i_reset,
    input logic                        i_stall,       // Combined stall and halt
    input logic                        i_restart,
    input logic                        i_redirect,
    input rv_frontend_pkg::inst_addr_t i_boot_addr,
    input rv_frontend_pkg::inst_addr_t i_imem_addr,
    input logic                        i_dec_valid,
    input rv_frontend_pkg::inst_addr_t i_dec_pc,
    input rv_frontend_pkg::tick_t      i_dec_tick
);

    int fail_count = 0;   // Read by the testbench

    redirect_then_bubble: assert property (@(posedge i_clock) disable iff (i_reset)
        i_redirect |=> !i_dec_valid)
    else
    begin
        fail_count++;
        $error("Redirect was not followed by a bubble");
    end

    // A stall freezes fetch and decode unless a restart overrides it
    stall_holds: assert property (@(posedge i_clock) disable iff (i_reset)
        i_stall && !i_restart |=>
            $stable(i_imem_addr) && $stable(i_dec_pc) && $stable(i_dec_valid) &&
            $stable(i_dec_tick))
    else
    begin
        fail_count++;
        $error("Front end moved while stalled");
    end

    restart_to_boot: assert property (@(posedge i_clock) disable iff (i_reset)
        i_restart |=> i_imem_addr == $past(i_boot_addr) && !i_dec_valid)
    else
    begin
        fail_count++;
        $error("Restart did not load the boot address with a bubble");
    end

endmodule

bind rv_frontend rv_frontend_properties u_props (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_stall     (stall),
    .i_restart   (restart),
    .i_redirect  (o_redirect),
    .i_boot_addr (boot_addr),
    .i_imem_addr (o_imem_addr),
    .i_dec_valid (o_dec_valid),
    .i_dec_pc    (o_dec_pc),
    .i_dec_tick  (o_dec_tick)
);

`default_nettype wire

// ==== tb_rv_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defs.svh"

module tb_rv_frontend;

    localparam int          PERIOD   = 40;
    localparam int          RUN_LEN  = 300;            // Bound on stimulus cycles
    localparam logic [31:0] NEW_BOOT = 32'h0000_0200;

    logic                        i_clock;
    logic                        i_reset;
    logic                        i_stall;
    logic                        i_cfg_write;
    logic                        i_cfg_addr;
    logic [31:0]                 i_cfg_data;
    rv_frontend_pkg::inst_t      i_imem_data;
    rv_frontend_pkg::inst_addr_t o_imem_addr;
    rv_frontend_pkg::inst_addr_t o_dec_pc;
    rv_frontend_pkg::opcode_e    o_dec_opcode;
    logic [4:0]                  o_dec_rd, o_dec_rs1, o_dec_rs2;
    logic [31:0]                 o_dec_imm;
    rv_frontend_pkg::tick_t      o_dec_tick;
    logic                        o_dec_valid;
    logic                        o_redirect;

    logic [31:0] prog [0:127];                         // One entry per halfword address
    logic [31:0] m_pc, m_d_pc, m_d_inst, m_boot;       // Reference model of fetch and IF/ID
    logic [15:0] m_tick, m_d_tick;
    logic        m_d_valid, m_halt, m_restart;
    integer      seed;
    int          errors;
    int          checks;

    rv_frontend uut (.*);

    assign i_imem_data = prog[o_imem_addr[7:1]];

    always #(PERIOD / 2) i_clock = ~i_clock;

    function automatic rv_frontend_pkg::opcode_e expected_opcode(input logic [31:0] inst);
        if (inst == 32'h0)
            return rv_frontend_pkg::op_illegal;
        if (inst[1:0] != 2'b11)
            return rv_frontend_pkg::op_compressed;
        case (inst[6:0])
            7'h37:   return rv_frontend_pkg::op_lui;
            7'h17:   return rv_frontend_pkg::op_auipc;
            7'h6f:   return rv_frontend_pkg::op_jal;
            7'h67:   return rv_frontend_pkg::op_jalr;
            7'h63:   return rv_frontend_pkg::op_branch;
            7'h03:   return rv_frontend_pkg::op_load;
            7'h23:   return rv_frontend_pkg::op_store;
            7'h13:   return rv_frontend_pkg::op_alu_imm;
            7'h33:   return rv_frontend_pkg::op_alu_reg;
            7'h73:   return rv_frontend_pkg::op_system;
            default: return rv_frontend_pkg::op_illegal;
        endcase
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] inst);
        logic signed [31:0] imm;
        case (expected_opcode(inst))
            rv_frontend_pkg::op_jalr, rv_frontend_pkg::op_load,
            rv_frontend_pkg::op_alu_imm, rv_frontend_pkg::op_system:
                imm = $signed(inst[31:20]);
            rv_frontend_pkg::op_store:
                imm = $signed({inst[31:25], inst[11:7]});
            rv_frontend_pkg::op_branch:
                imm = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
            rv_frontend_pkg::op_lui, rv_frontend_pkg::op_auipc:
                imm = {inst[31:12], 12'h000};
            rv_frontend_pkg::op_jal:
                imm = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
            default:
                imm = 0;
        endcase
        return imm;
    endfunction

    function automatic logic jal_in_decode();
        return m_d_valid && !(i_stall | m_halt) &&
               expected_opcode(m_d_inst) == rv_frontend_pkg::op_jal;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] word);
        prog[addr[7:1]] = word;
    endtask

    task automatic write_config(input logic addr, input logic [31:0] data);
        @(posedge i_clock);
        i_cfg_write <= 1'b1;
        i_cfg_addr  <= addr;
        i_cfg_data  <= data;
        @(posedge i_clock);
        i_cfg_write <= 1'b0;
    endtask

    always @(posedge i_clock)
    begin : model_step
        logic [31:0] word;
        logic [31:0] target;
        logic        jump;
        logic        hold;
        word   = prog[m_pc[7:1]];
        target = m_d_pc + expected_imm(m_d_inst);
        jump   = jal_in_decode();
        hold   = i_stall | m_halt;
        if (i_reset)
        begin
            m_pc      = `RV_BOOT_ADDR;
            m_tick    = '0;
            m_d_valid = 1'b0;
            m_d_pc    = `RV_BOOT_ADDR - 4;
            m_d_inst  = '0;
            m_d_tick  = '0;
            m_boot    = `RV_BOOT_ADDR;
            m_halt    = 1'b0;
            m_restart = 1'b0;
        end
        else
        begin
            if (m_restart || jump)
            begin
                m_d_valid = 1'b0;                  // Bubble keeps PC and tick
                m_d_inst  = '0;
                m_d_pc    = m_pc;
                m_d_tick  = m_tick;
            end
            else if (!hold)
            begin
                m_d_valid = 1'b1;
                m_d_pc    = m_pc;
                m_d_inst  = word;
                m_d_tick  = m_tick;
            end
            if (m_restart)
                m_pc = m_boot;
            else if (jump)
                m_pc = target;
            else if (!hold)
            begin
                m_pc   = m_pc + ((word[1:0] == 2'b11) ? 4 : 2);
                m_tick = m_tick + 1;
            end
            m_restart = 1'b0;
            if (i_cfg_write && i_cfg_addr == `RV_CFG_BOOT)
                m_boot = i_cfg_data;
            else if (i_cfg_write)
            begin
                m_halt    = i_cfg_data[0];
                m_restart = i_cfg_data[1];
            end
        end
    end

    // Outputs are settled half a period after the edge
    always @(negedge i_clock)
    begin
        if (!i_reset)
        begin
            compare_value("o_imem_addr", o_imem_addr, m_pc);
            compare_value("o_dec_valid", o_dec_valid, m_d_valid);
            compare_value("o_dec_pc", o_dec_pc, m_d_pc);
            compare_value("o_dec_opcode", o_dec_opcode, expected_opcode(m_d_inst));
            compare_value("o_dec_rd", o_dec_rd, m_d_inst[11:7]);
            compare_value("o_dec_rs1", o_dec_rs1, m_d_inst[19:15]);
            compare_value("o_dec_rs2", o_dec_rs2, m_d_inst[24:20]);
            compare_value("o_dec_imm", o_dec_imm, expected_imm(m_d_inst));
            compare_value("o_dec_tick", o_dec_tick, m_d_tick);
            compare_value("o_redirect", o_redirect, jal_in_decode());
        end
    end

    initial
    begin
        int idx;
        seed        = 32'h1f80;
        errors      = 0;
        checks      = 0;
        i_clock     = 1'b0;
        i_reset     = 1'b1;
        i_stall     = 1'b0;
        i_cfg_write = 1'b0;
        i_cfg_addr  = 1'b0;
        i_cfg_data  = '0;
        for (idx = 0; idx < 128; idx++)
            prog[idx] = {5'b0, 7'(idx), 5'd1, 3'b000, 5'd2, 7'h13};   // addi x2, x1, index
        store_word(32'h100, 32'h1234_52b7);        // lui x5, 0x12345
        store_word(32'h104, 32'hfff2_8313);        // addi x6, x5, -1
        store_word(32'h108, 32'h0000_0085);        // c.addi
        store_word(32'h10a, 32'h0062_83b3);        // add x7, x5, x6
        store_word(32'h10e, 32'h0071_2423);        // sw x7, 8(x2)
        store_word(32'h112, 32'h0081_2403);        // lw x8, 8(x2)
        store_word(32'h116, 32'h0062_8863);        // beq x5, x6, +16
        store_word(32'h11a, 32'h0000_4501);        // c.li
        store_word(32'h11c, 32'h0200_00ef);        // jal x1, +0x20
        store_word(32'h13c, 32'h0000_0000);        // All-zero word
        store_word(32'h13e, 32'h0000_007f);        // Unknown major opcode
        store_word(32'h142, 32'h0000_0073);        // ecall
        store_word(32'h146, 32'h0000_1197);        // auipc x3, 1
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
        repeat (40) @(posedge i_clock);            // Straight run through the JAL
        repeat (40)
        begin
            @(posedge i_clock);
            i_stall <= ($random(seed) & 3) == 0;
        end
        @(posedge i_clock);
        i_stall <= 1'b0;
        write_config(`RV_CFG_CTRL, 32'h1);         // Halt
        repeat (6) @(posedge i_clock);
        write_config(`RV_CFG_BOOT, NEW_BOOT);
        repeat (1 + ($random(seed) & 7)) @(posedge i_clock);
        write_config(`RV_CFG_CTRL, 32'h2);         // Release halt and restart
        repeat (40) @(posedge i_clock);
        $display("Checks %0d, model errors %0d, assertion errors %0d",
                 checks, errors, uut.u_props.fail_count);
        if (errors == 0 && uut.u_props.fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #((RUN_LEN + 100) * PERIOD);               // 400 clock periods
        $display("Watchdog expired before the stimulus completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
rv_frontend_pkg.sv
fetch_bus_if.sv
rv_frontend_regs.sv
rv_fetch_stage.sv
rv_pipeline_if_id.sv
rv_decode_stage.sv
rv_frontend.sv
rv_frontend_properties.sv
tb_rv_frontend.sv

// ==== Bender.yml ====
package:
  name: rv_frontend

export_include_dirs:
  - .

sources:
  - rv_frontend_pkg.sv
  - fetch_bus_if.sv
  - rv_frontend_regs.sv
  - rv_fetch_stage.sv
  - rv_pipeline_if_id.sv
  - rv_decode_stage.sv
  - rv_frontend.sv
  - target: test
    files:
      - rv_frontend_properties.sv
      - tb_rv_frontend.sv
